/* build.f */
+incdir+hw
+incdir+tb
hw/lab_pkg.sv
hw/tone_phase.sv
hw/waveform_sel.sv
hw/scope_capture.sv
hw/oscilloscope.sv
hw/lab_top.sv
tb/lab_top_tb.sv

/* hw/lab_macros.svh */
`ifndef LAB_MACROS_SVH
`define LAB_MACROS_SVH

// ----------------------------------------------------------------------
// audio path widths

`define W_SAMPLE     16
`define W_PHASE      16
`define W_OCTAVE     3

// phase increment at octave 0
`define TONE_STEP    64

// ----------------------------------------------------------------------
// oscilloscope trace

// keep one sample in this many
`define SCOPE_DECIM  4
// sample to screen rows
`define SCOPE_SHIFT  8

// ----------------------------------------------------------------------
// board and screen

`define SCREEN_W     640
`define SCREEN_H     480
`define W_X          10
`define W_Y          9
`define W_KEY        4
`define W_COLOR      4

`endif

/* hw/lab_pkg.sv */
`include "lab_macros.svh"

package lab_pkg;

    // ------------------------------------------------------------------
    // audio

    // signed pcm sample for the sound output
    typedef logic signed [`W_SAMPLE-1:0] sample_t;

    // unsigned phase, one full period per wrap
    typedef logic [`W_PHASE-1:0] phase_t;

    typedef logic [`W_OCTAVE-1:0] octave_t;

    // one-hot key selects the waveform
    typedef logic [`W_KEY-1:0] key_t;

    // ------------------------------------------------------------------
    // raster and scope

    typedef logic [`W_X-1:0] x_t;
    typedef logic [`W_Y-1:0] y_t;

    typedef logic [`W_COLOR-1:0] color_t;

    // trace memory entry, a screen row
    typedef logic [`W_Y-1:0] row_t;

    typedef enum logic [1:0] {
        wait_frame,
        armed,
        filling,
        holding
    } capture_state_t;

endpackage

/* hw/lab_top.sv */
`include "lab_macros.svh"

module lab_top (
    input  logic             clk,
    input  logic             rst,
    input  lab_pkg::key_t    key,
    input  logic [7:0]       sw,
    output logic [7:0]       led,
    output logic [7:0]       abcdefgh,
    output logic [7:0]       digit,
    input  lab_pkg::x_t      x,
    input  lab_pkg::y_t      y,
    output lab_pkg::color_t  red,
    output lab_pkg::color_t  green,
    output lab_pkg::color_t  blue,
    output lab_pkg::sample_t sound
);

    import lab_pkg::*;

    octave_t octave;
    sample_t sample;

    assign octave = sw[`W_OCTAVE-1:0];

    // only the rightmost digit is lit
    assign digit = 8'b0000_0001;

    // ------------------------------------------------------------------
    // tone generator and scope

    waveform_sel tone_gen (
        .clk      (clk),
        .rst      (rst),
        .octave   (octave),
        .waveform (key),
        .sample   (sample)
    );

    assign sound = sample;

    oscilloscope scope0 (
        .clk    (clk),
        .rst    (rst),
        .sample (sample),
        .x      (x),
        .y      (y),
        .red    (red),
        .green  (green),
        .blue   (blue)
    );

    // ------------------------------------------------------------------
    // leds and seven segment letter

    // segment order is a..g then the dot
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            led      <= '0;
            abcdefgh <= '0;
        end else begin
            led <= {{(8 - `W_KEY){1'b0}}, key};
            case (key)
                // S
                key_t'(1): abcdefgh <= 8'b1011_0110;
                // T
                key_t'(2): abcdefgh <= 8'b0001_1110;
                // Q
                key_t'(4): abcdefgh <= 8'b1110_0110;
                default:   abcdefgh <= 8'b0000_0000;
            endcase
        end
    end

endmodule

/* hw/oscilloscope.sv */
`include "lab_macros.svh"

module oscilloscope (
    input  logic             clk,
    input  logic             rst,
    input  lab_pkg::sample_t sample,
    input  lab_pkg::x_t      x,
    input  lab_pkg::y_t      y,
    output lab_pkg::color_t  red,
    output lab_pkg::color_t  green,
    output lab_pkg::color_t  blue
);

    import lab_pkg::*;

    localparam y_t     center_y   = y_t'(`SCREEN_H / 2);
    localparam color_t full_level = '1;
    localparam color_t grid_level = color_t'(4);

    row_t trace_row;
    y_t   y_d;

    // ------------------------------------------------------------------
    // capture and trace read

    // the raster column doubles as the read address
    scope_capture capture0 (
        .clk    (clk),
        .rst    (rst),
        .sample (sample),
        .x      (x),
        .y      (y),
        .rd_col (x),
        .rd_row (trace_row)
    );

    // line y up with the registered trace row
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            y_d <= '0;
        end else begin
            y_d <= y;
        end
    end

    // ------------------------------------------------------------------
    // pixel colors

    // trace on top, then the center grid line, then background
    always_comb begin
        red   = '0;
        green = '0;
        blue  = '0;
        if (trace_row == y_d) begin
            green = full_level;
        end else if (y_d == center_y) begin
            blue = grid_level;
        end
    end

endmodule

/* hw/scope_capture.sv */
`include "lab_macros.svh"

module scope_capture (
    input  logic             clk,
    input  logic             rst,
    input  lab_pkg::sample_t sample,
    input  lab_pkg::x_t      x,
    input  lab_pkg::y_t      y,
    input  lab_pkg::x_t      rd_col,
    output lab_pkg::row_t    rd_row
);

    import lab_pkg::*;

    localparam int w_decim    = $clog2(`SCOPE_DECIM + 1);
    localparam int center_row = `SCREEN_H / 2;

    localparam logic [w_decim-1:0] decim_reload = w_decim'(`SCOPE_DECIM - 1);
    localparam x_t                 last_col     = x_t'(`SCREEN_W - 1);
    localparam row_t               center       = row_t'(center_row);

    capture_state_t       state;
    logic [w_decim-1:0]   decim_cnt;
    x_t                   col;
    logic                 prev_neg;
    logic                 frame_start;
    logic                 rising;
    logic                 wr_en;
    x_t                   wr_col;
    sample_t              scaled;
    row_t                 wr_row;
    row_t                 trace_mem [`SCREEN_W];
    logic [`SCREEN_W-1:0] written;
    row_t                 mem_q;
    logic                 hit_q;

    // ------------------------------------------------------------------
    // trigger and write control

    assign frame_start = (x == '0) && (y == '0);
    assign rising      = prev_neg && !sample[`W_SAMPLE-1];

    // column 0 takes the crossing sample itself
    assign wr_en  = ((state == armed) && rising) || ((state == filling) && (decim_cnt == '0));
    assign wr_col = (state == armed) ? x_t'(0) : col;

    // positive samples go up the screen
    assign scaled = sample >>> `SCOPE_SHIFT;
    assign wr_row = row_t'(center_row - int'(scaled));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= wait_frame;
            decim_cnt <= '0;
            col       <= '0;
        end else begin
            case (state)
                wait_frame: begin
                    if (frame_start) begin
                        state <= armed;
                    end
                end
                armed: begin
                    if (rising) begin
                        state     <= filling;
                        col       <= x_t'(1);
                        decim_cnt <= decim_reload;
                    end
                end
                filling: begin
                    if (decim_cnt == '0) begin
                        decim_cnt <= decim_reload;
                        if (col == last_col) begin
                            state <= holding;
                        end else begin
                            col <= col + x_t'(1);
                        end
                    end else begin
                        decim_cnt <= decim_cnt - 1'b1;
                    end
                end
                holding: begin
                    // trace stays frozen until the next frame
                    if (frame_start) begin
                        state <= armed;
                    end
                end
                default: state <= wait_frame;
            endcase
        end
    end

    // sign history and per-column written flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev_neg <= 1'b0;
            written  <= '0;
        end else begin
            prev_neg <= sample[`W_SAMPLE-1];
            if (wr_en) begin
                written[wr_col] <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // trace memory

    always_ff @(posedge clk) begin
        if (wr_en) begin
            trace_mem[wr_col] <= wr_row;
        end
    end

    always_ff @(posedge clk) begin
        mem_q <= trace_mem[rd_col];
    end

    // off-screen or never written columns sit on the center line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= (rd_col < `SCREEN_W) && written[rd_col];
        end
    end

    assign rd_row = hit_q ? mem_q : center;

endmodule

/* hw/tone_phase.sv */
`include "lab_macros.svh"

module tone_phase (
    input  logic             clk,
    input  logic             rst,
    input  lab_pkg::octave_t octave,
    output lab_pkg::phase_t  phase
);

    import lab_pkg::*;

    // ------------------------------------------------------------------
    // step selection

    // increment at the lowest octave
    localparam phase_t base_step = phase_t'(`TONE_STEP);

    phase_t step;

    // every octave up doubles the step, so the pitch doubles too
    always_comb begin
        step = base_step << octave;
    end

    // ------------------------------------------------------------------
    // accumulator

    // free running, wraps once per tone period
    // period in cycles is 2**W_PHASE / step
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= '0;
        end else begin
            phase <= phase + step;
        end
    end

endmodule

/* hw/waveform_sel.sv */
`include "lab_macros.svh"

module waveform_sel (
    input  logic             clk,
    input  logic             rst,
    input  lab_pkg::octave_t octave,
    input  lab_pkg::key_t    waveform,
    output lab_pkg::sample_t sample
);

    import lab_pkg::*;

    // ------------------------------------------------------------------
    // constants

    // midpoint of the phase range, also the offset of an unsigned ramp
    localparam phase_t  half_scale = phase_t'(1) << (`W_PHASE - 1);

    // square levels, symmetric around zero
    localparam sample_t full_pos   = sample_t'(half_scale - phase_t'(1));
    localparam sample_t full_neg   = -full_pos;

    phase_t  phase;
    phase_t  tri_up;
    phase_t  tri_fold;
    sample_t saw_value;
    sample_t tri_value;
    sample_t sqr_value;
    sample_t next_sample;

    tone_phase phase_gen (
        .clk    (clk),
        .rst    (rst),
        .octave (octave),
        .phase  (phase)
    );

    // ------------------------------------------------------------------
    // waveform shapes

    // sawtooth: offset binary to two's complement
    always_comb begin
        saw_value = sample_t'({~phase[`W_PHASE-1], phase[`W_PHASE-2:0]});
    end

    // triangle: ramp up over the first half, back down over the second
    always_comb begin
        tri_up = {phase[`W_PHASE-2:0], 1'b0};
        if (phase[`W_PHASE-1]) begin
            tri_fold = ~tri_up;
        end else begin
            tri_fold = tri_up;
        end
        tri_value = sample_t'(tri_fold - half_scale);
    end

    always_comb begin
        if (phase[`W_PHASE-1]) begin
            sqr_value = full_neg;
        end else begin
            sqr_value = full_pos;
        end
    end

    // ------------------------------------------------------------------
    // selection

    // one key at a time, anything else is silence
    always_comb begin
        case (waveform)
            key_t'(1): next_sample = saw_value;
            key_t'(2): next_sample = tri_value;
            key_t'(4): next_sample = sqr_value;
            default:   next_sample = '0;
        endcase
    end

    // one cycle behind the phase it was built from
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sample <= '0;
        end else begin
            sample <= next_sample;
        end
    end

endmodule

/* tb/lab_top_tb_checks.svh */
`ifndef LAB_TOP_TB_CHECKS_SVH
`define LAB_TOP_TB_CHECKS_SVH

// ----------------------------------------------------------------------
// compare tasks, one per kind of result

// audio samples, shown as signed decimal
task automatic check_sample(
    input string   name,
    input sample_t expected,
    input sample_t actual
);
    if (actual !== expected) begin
        $display("error at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
        $display("Finished with errors");
        $fatal(1);
    end
endtask

// led and segment patterns, shown bit by bit
task automatic check_code(
    input string      name,
    input logic [7:0] expected,
    input logic [7:0] actual
);
    if (actual !== expected) begin
        $display("error at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
        $display("Finished with errors");
        $fatal(1);
    end
endtask

// one color channel of the scope pixel
task automatic check_color(
    input string  name,
    input color_t expected,
    input color_t actual
);
    if (actual !== expected) begin
        $display("error at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
        $display("Finished with errors");
        $fatal(1);
    end
endtask

`endif

/* tb/lab_top_tb.sv */
`include "lab_macros.svh"

module lab_top_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import lab_pkg::*;

    localparam int n_steps        = 18;
    localparam int kind_fixed     = 0;
    localparam int kind_rand      = 1;
    // octave used while the scope captures, and a bound on one tone period
    localparam int scope_octave   = 3;
    localparam int crossing_limit = 2 * (1 << `W_PHASE) / (`TONE_STEP << scope_octave);
    localparam int fill_cycles    = `SCREEN_W * `SCOPE_DECIM;
    localparam int center_row     = `SCREEN_H / 2;
    localparam int top_row        = center_row - 32767 / (1 << `SCOPE_SHIFT);

    typedef struct packed {
        key_t        key;
        logic [7:0]  sw;
        logic [15:0] cycles;
        logic [1:0]  kind;
    } step_t;

    logic       clk;
    logic       rst;
    key_t       key;
    logic [7:0] sw;
    logic [7:0] led;
    logic [7:0] abcdefgh;
    logic [7:0] digit;
    x_t         x;
    y_t         y;
    color_t     red;
    color_t     green;
    color_t     blue;
    sample_t    sound;

    // reference model state
    int          model_phase;
    sample_t     exp_sound;
    sample_t     prev_sound;
    logic [31:0] rng_state;
    step_t       steps [n_steps];
    logic        table_ready;

    lab_top dut0 (
        .clk      (clk),
        .rst      (rst),
        .key      (key),
        .sw       (sw),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit),
        .x        (x),
        .y        (y),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .sound    (sound)
    );

`include "lab_top_tb_checks.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // reference model

    function automatic sample_t ref_sample(input int ph, input key_t k);
        int t;
        int v;
        v = 0;
        case (k)
            key_t'(1): v = ph - 32768;
            key_t'(2): begin
                t = (ph * 2) % 65536;
                if (ph >= 32768) begin
                    t = 65535 - t;
                end
                v = t - 32768;
            end
            key_t'(4): v = (ph < 32768) ? 32767 : -32767;
            default:   v = 0;
        endcase
        return sample_t'(v);
    endfunction

    // letters S, T and Q
    function automatic logic [7:0] ref_segments(input key_t k);
        case (k)
            key_t'(1): return 8'b1011_0110;
            key_t'(2): return 8'b0001_1110;
            key_t'(4): return 8'b1110_0110;
            default:   return 8'b0000_0000;
        endcase
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic step_t make_step(input int k, input int s, input int c, input int kind);
        step_t e;
        e.key    = key_t'(k);
        e.sw     = 8'(s);
        e.cycles = 16'(c);
        e.kind   = 2'(kind);
        return e;
    endfunction

    // ------------------------------------------------------------------
    // stimulus table: key, sw, cycles, kind

    task automatic load_table();
        steps[0]  = make_step(1, 0, 40, kind_fixed);
        steps[1]  = make_step(1, 2, 300, kind_fixed);
        steps[2]  = make_step(2, 3, 200, kind_fixed);
        steps[3]  = make_step(4, 4, 100, kind_fixed);
        // silence, phase keeps running underneath
        steps[4]  = make_step(3, 1, 20, kind_fixed);
        steps[5]  = make_step(2, 1, 50, kind_fixed);
        steps[6]  = make_step(0, 5, 10, kind_fixed);
        steps[7]  = make_step(8, 2, 10, kind_fixed);
        steps[8]  = make_step(1, 5, 30, kind_fixed);
        steps[9]  = make_step(4, 0, 60, kind_rand);
        steps[10] = make_step(1, 0, 60, kind_rand);
        steps[11] = make_step(2, 0, 60, kind_rand);
        steps[12] = make_step(5, 6, 15, kind_fixed);
        steps[13] = make_step(6, 7, 10, kind_fixed);
        steps[14] = make_step(7, 3, 10, kind_fixed);
        steps[15] = make_step(15, 3, 10, kind_fixed);
        steps[16] = make_step(4, 6, 80, kind_fixed);
        steps[17] = make_step(1, 7, 80, kind_fixed);
    endtask

    // one clock edge, then advance the model and compare
    task automatic run_cycle();
        @(posedge clk);
        #1;
        prev_sound  = exp_sound;
        exp_sound   = ref_sample(model_phase, key);
        model_phase = (model_phase + (`TONE_STEP << sw[2:0])) % (1 << `W_PHASE);
        check_sample("sound", exp_sound, sound);
        check_code("led", {4'b0000, key}, led);
        check_code("abcdefgh", ref_segments(key), abcdefgh);
        check_code("digit", 8'b0000_0001, digit);
    endtask

    task automatic probe_pixel(input int px, input int py, input int er, input int eg,
                               input int eb);
        x = x_t'(px);
        y = y_t'(py);
        run_cycle();
        check_color("red", color_t'(er), red);
        check_color("green", color_t'(eg), green);
        check_color("blue", color_t'(eb), blue);
    endtask

    // ------------------------------------------------------------------
    // main sequence

    initial begin
        int waited;
        load_table();
        table_ready = 1'b1;
        rst         = 1'b1;
        key         = '0;
        sw          = '0;
        x           = x_t'(1);
        y           = y_t'(1);
        model_phase = 0;
        exp_sound   = '0;
        prev_sound  = '0;
        rng_state   = 32'd66890;
        repeat (3) @(posedge clk);
        #1;
        check_sample("sound", '0, sound);
        check_code("led", 8'h00, led);
        check_code("abcdefgh", 8'h00, abcdefgh);
        check_color("red", '0, red);
        check_color("green", '0, green);
        check_color("blue", '0, blue);
        rst = 1'b0;

        for (int i = 0; i < n_steps; i++) begin
            key = steps[i].key;
            if (steps[i].kind == 2'(kind_rand)) begin
                rng_state = xorshift32(rng_state);
                sw        = rng_state[7:0];
            end else begin
                sw = steps[i].sw;
            end
            repeat (steps[i].cycles) run_cycle();
        end

        // square wave into the scope, arm on a frame start
        key = key_t'(4);
        sw  = 8'(scope_octave);
        repeat (8) run_cycle();
        x = '0;
        y = '0;
        run_cycle();
        y = y_t'(1);
        waited = 0;
        while (!(prev_sound < 0 && exp_sound >= 0)) begin
            if (waited >= crossing_limit) begin
                $display("no rising zero crossing seen within %0d cycles", crossing_limit);
                $display("Finished with errors");
                $fatal(1);
            end else begin
                run_cycle();
                waited++;
            end
        end
        repeat (fill_cycles) run_cycle();

        // column 0 holds the crossing sample
        probe_pixel(0, top_row, 0, 15, 0);
        probe_pixel(0, center_row, 0, 0, 4);
        probe_pixel(0, 300, 0, 0, 0);

        $display("Finished with no errors");
        $finish;
    end

    // ------------------------------------------------------------------
    // watchdog

    initial begin
        int total;
        wait (table_ready === 1'b1);
        total = 3 + 8 + 1 + crossing_limit + fill_cycles + 3;
        for (int i = 0; i < n_steps; i++) begin
            total += int'(steps[i].cycles);
        end
        total = 2 * total + 100;
        #(total * 10);
        $display("watchdog expired, run did not end within %0d cycles", total);
        $display("Finished with errors");
        $fatal(1);
    end

endmodule
